/* source/cart_pkg.sv */
//==========================================================
// Cartridge definitions
// ROM header locations, load options and decoded cartridge
// information shared by the decode and backup logic
//==========================================================

package cart_pkg;

	// Width of the ROM and RAM address masks
	localparam int MASK_W = 24;

	// Copier header in front of the ROM image
	localparam logic [31:0] HEADER_SKIP = 32'd512;

	// Header size word offsets inside the image
	// RAM size word follows 2 bytes later
	localparam logic [31:0] LOROM_HDR   = 32'h7FD6;
	localparam logic [31:0] HIROM_HDR   = 32'hFFD6;
	localparam logic [31:0] EXHIROM_HDR = 32'h40FFD6;

	typedef enum logic [2:0] {
		hdr_auto    = 3'd0,
		hdr_none    = 3'd1,
		hdr_lorom   = 3'd2,
		hdr_hirom   = 3'd3,
		hdr_exhirom = 3'd4
	} hdr_mode_e;

	// Power-on work RAM contents
	typedef enum logic [1:0] {
		fill_9966 = 2'd0,
		fill_00ff = 2'd1,
		fill_55   = 2'd2,
		fill_ff   = 2'd3
	} fill_pattern_e;

	typedef struct packed {
		hdr_mode_e     hdr_mode;
		fill_pattern_e fill_pattern;
		logic [1:0]    region_sel;   // 0 auto, 2 NTSC, 3 PAL
		logic          bk_load;
		logic          bk_save;
		logic          autosave;
	} cart_opts_t;

	typedef struct packed {
		logic [7:0]        rom_type;
		logic [MASK_W-1:0] rom_mask;
		logic [MASK_W-1:0] ram_mask;
		logic              region;
	} cart_info_t;

endpackage

/* source/host_pkg.sv */
//==========================================================
// Host interface definitions
// Download stream, cheat codes and SD sector requests
//==========================================================

package host_pkg;

	// Download index reserved for cheat files
	localparam logic [7:0] CHEAT_INDEX = 8'hFF;

	// One word of the host download stream
	typedef struct packed {
		logic [24:0] addr;
		logic [15:0] data;
		logic        wr;
	} dl_word_t;

	// Complete cheat code, flags in the top word
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	// Sector request towards the SD image
	typedef struct packed {
		logic [31:0] lba;
		logic        rd;
		logic        wr;
	} sd_req_t;

	// Backup RAM transfer direction
	typedef enum logic [1:0] {
		bk_idle    = 2'd0,
		bk_loading = 2'd1,
		bk_saving  = 2'd2
	} bk_state_e;

endpackage

/* source/header_decode.sv */
//==========================================================
// ROM header decode
// Picks ROM type, size fields and region out of the
// cartridge download and derives the address masks
//==========================================================

`timescale 1ns/1ns

module header_decode (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 cart_download,
	input  host_pkg::dl_word_t   dl,
	input  cart_pkg::cart_opts_t opts,
	output cart_pkg::cart_info_t info,
	output logic                 pal
);
	import cart_pkg::*;

	logic [3:0]  rom_size;
	logic [3:0]  ram_size;
	logic        region;
	logic [7:0]  rom_type;
	logic        hdr_fixed;
	logic [31:0] hdr_addr;
	logic [31:0] wr_addr;

	assign wr_addr = {7'd0, dl.addr};

	// Location of the size word for a forced mapping
	always_comb begin
		hdr_fixed = 1'b1;
		case (opts.hdr_mode)
			hdr_lorom:   hdr_addr = LOROM_HDR + HEADER_SKIP;
			hdr_hirom:   hdr_addr = HIROM_HDR + HEADER_SKIP;
			hdr_exhirom: hdr_addr = EXHIROM_HDR + HEADER_SKIP;
			default: begin
				hdr_fixed = 1'b0;
				hdr_addr  = '0;
			end
		endcase
	end

	//==========================================================
	// Field capture
	//==========================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_size <= 4'hC;
			ram_size <= 4'h0;
			region   <= 1'b0;
			rom_type <= 8'd0;
		end else if (cart_download && dl.wr) begin
			if (dl.addr == '0) begin
				rom_size <= 4'hC;
				ram_size <= 4'h0;
				// Auto mode takes both sizes from the first byte
				if (opts.hdr_mode == hdr_auto && dl.data[7:0] != 8'h00) begin
					ram_size <= dl.data[7:4];
					rom_size <= dl.data[3:0];
				end
				case (opts.hdr_mode)
					hdr_none:    rom_type <= 8'd0;
					hdr_lorom:   rom_type <= 8'd0;
					hdr_hirom:   rom_type <= 8'd1;
					hdr_exhirom: rom_type <= 8'd2;
					default:     rom_type <= dl.data[15:8];
				endcase
			end

			if (dl.addr == 25'd2)
				region <= dl.data[8];

			if (hdr_fixed) begin
				if (wr_addr == hdr_addr)
					rom_size <= dl.data[11:8];
				if (wr_addr == hdr_addr + 32'd2)
					ram_size <= dl.data[3:0];
			end
		end
	end

	//==========================================================
	// Masks and region
	//==========================================================

	always_comb begin
		info.rom_type = rom_type;
		info.rom_mask = (MASK_W'(1024) << rom_size) - MASK_W'(1);
		if (ram_size != 4'h0)
			info.ram_mask = (MASK_W'(1024) << ram_size) - MASK_W'(1);
		else
			info.ram_mask = '0;
		info.region = region;
	end

	// Region override from the menu, held while loading
	always_ff @(posedge clk_sys) begin
		if (reset)
			pal <= 1'b0;
		else if (!cart_download)
			pal <= (opts.region_sel == 2'd0) ? region : opts.region_sel[0];
	end

	// Cartridge info only moves as a result of a download write
	assert property (@(posedge clk_sys) disable iff (reset)
		(!$past(cart_download) && !$past(reset)) |-> $stable(info));

endmodule

/* source/cheat_decode.sv */
//==========================================================
// Cheat code assembly
// Collects eight 16-bit words into one 128-bit code
//==========================================================

`timescale 1ns/1ns

module cheat_decode (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  code_download,
	input  host_pkg::dl_word_t    dl,
	output host_pkg::cheat_code_t cheat,
	output logic                  cheat_valid,
	output logic                  cheat_clear
);

	logic code_wr;

	assign code_wr = code_download && dl.wr;

	// Strobes for a finished code and a new cheat file
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cheat_valid <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			cheat_valid <= code_wr && (dl.addr[3:0] == 4'd14);
			cheat_clear <= code_wr && (dl.addr == '0);
		end
	end

	// Word placement, low half first
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (dl.addr[3:0])
				4'd0:    cheat.flags[15:0]    <= dl.data;
				4'd2:    cheat.flags[31:16]   <= dl.data;
				4'd4:    cheat.address[15:0]  <= dl.data;
				4'd6:    cheat.address[31:16] <= dl.data;
				4'd8:    cheat.compare[15:0]  <= dl.data;
				4'd10:   cheat.compare[31:16] <= dl.data;
				4'd12:   cheat.replace[15:0]  <= dl.data;
				4'd14:   cheat.replace[31:16] <= dl.data;
				default: ;
			endcase
		end
	end

	// One strobe per code
	assert property (@(posedge clk_sys) disable iff (reset)
		cheat_valid |=> !cheat_valid);

endmodule

/* source/ram_clear.sv */
//==========================================================
// Work RAM clear
// Sweeps every work RAM address once per cartridge load
// and supplies the selected power-on pattern
//==========================================================

`timescale 1ns/1ns

module ram_clear #(
	parameter int FILL_BITS = 17
) (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    cart_download,
	input  cart_pkg::fill_pattern_e pattern,
	output logic [FILL_BITS-1:0]    fill_addr,
	output logic [7:0]              fill_data,
	output logic                    fill_we
);
	import cart_pkg::*;

	logic download_q;

	// Start on download rise, stop after the last address
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			download_q <= 1'b0;
			fill_we    <= 1'b0;
			fill_addr  <= '0;
		end else begin
			download_q <= cart_download;
			if (cart_download && !download_q)
				fill_we <= 1'b1;

			if (fill_we) begin
				fill_addr <= fill_addr + 1'b1;
				if (&fill_addr)
					fill_we <= 1'b0;
			end else begin
				fill_addr <= '0;
			end
		end
	end

	// Pattern generator
	always_comb begin
		case (pattern)
			fill_9966: fill_data = (fill_addr[8] ^ fill_addr[2]) ? 8'h66 : 8'h99;
			fill_00ff: fill_data = (fill_addr[9] ^ fill_addr[0]) ? 8'hFF : 8'h00;
			fill_55:   fill_data = 8'h55;
			default:   fill_data = 8'hFF;
		endcase
	end

	// Each sweep begins at address zero
	assert property (@(posedge clk_sys) disable iff (reset)
		!fill_we |-> (fill_addr == '0));

endmodule

/* source/backup_sequencer.sv */
//==========================================================
// Backup RAM sequencer
// Loads and saves battery RAM sector by sector through
// SD image requests, with autosave on menu open
//==========================================================

`timescale 1ns/1ns

module backup_sequencer (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 cart_download,
	input  logic [23:0]          ram_mask,
	input  cart_pkg::cart_opts_t opts,
	input  logic                 osd_open,
	input  logic                 img_mounted,
	input  logic                 img_readonly,
	input  logic [31:0]          img_size,
	input  logic                 bsram_write,
	input  logic                 sd_ack,
	output host_pkg::sd_req_t    sd,
	output host_pkg::bk_state_e  state,
	output logic                 pending
);
	import host_pkg::*;

	logic bk_ena;
	logic download_q;
	logic load_q;
	logic save_q;
	logic ack_q;
	logic save_req;
	logic load_edge;
	logic start_user;
	logic start_auto;
	logic last_sector;

	// Menu save or autosave of dirty RAM
	assign save_req    = opts.bk_save | (pending & osd_open & opts.autosave);
	assign load_edge   = opts.bk_load && !load_q;
	assign start_user  = bk_ena && (load_edge || (save_req && !save_q));
	assign start_auto  = bk_ena && download_q && !cart_download && (img_size != 32'd0);
	assign last_sector = sd.lba >= {17'd0, ram_mask[23:9]};

	//==========================================================
	// Enable and pending flag
	//==========================================================

	// Save image is mounted by the end of the download
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bk_ena     <= 1'b0;
			download_q <= 1'b0;
		end else begin
			download_q <= cart_download;
			if (cart_download && !download_q)
				bk_ena <= 1'b0;
			if (cart_download && img_mounted && !img_readonly)
				bk_ena <= |ram_mask;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			pending <= 1'b0;
		else if (bk_ena && !osd_open && bsram_write)
			pending <= 1'b1;
		else if (state != bk_idle)
			pending <= 1'b0;
	end

	//==========================================================
	// Sector sequencing
	//==========================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state  <= bk_idle;
			sd.rd  <= 1'b0;
			sd.wr  <= 1'b0;
			load_q <= 1'b0;
			save_q <= 1'b0;
			ack_q  <= 1'b0;
		end else begin
			load_q <= opts.bk_load;
			save_q <= save_req;
			ack_q  <= sd_ack;

			// Request accepted
			if (sd_ack && !ack_q) begin
				sd.rd <= 1'b0;
				sd.wr <= 1'b0;
			end

			case (state)
				bk_idle: begin
					if (start_user) begin
						if (load_edge)
							state <= bk_loading;
						else
							state <= bk_saving;
						sd.lba <= '0;
						sd.rd  <= load_edge;
						sd.wr  <= !load_edge;
					end
					// End of cartridge download pulls in the save file
					if (start_auto) begin
						state  <= bk_loading;
						sd.lba <= '0;
						sd.rd  <= 1'b1;
						sd.wr  <= 1'b0;
					end
				end
				default: begin
					if (ack_q && !sd_ack) begin
						if (last_sector) begin
							state <= bk_idle;
						end else begin
							sd.lba <= sd.lba + 32'd1;
							sd.rd  <= (state == bk_loading);
							sd.wr  <= (state == bk_saving);
						end
					end
				end
			endcase
		end
	end

	// Never read and write the image at once
	assert property (@(posedge clk_sys) disable iff (reset)
		!(sd.rd && sd.wr));

endmodule

/* source/cart_loader_top.sv */
//==========================================================
// Cartridge load controller
// Header decode, cheats, RAM clear and backup RAM with the
// combined core reset and user LED
//==========================================================

`timescale 1ns/1ns

module cart_loader_top #(
	parameter int FILL_BITS = 17
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  download,
	input  logic [7:0]            dl_index,
	input  host_pkg::dl_word_t    dl,
	input  cart_pkg::cart_opts_t  opts,
	input  logic                  osd_open,
	input  logic                  img_mounted,
	input  logic                  img_readonly,
	input  logic [31:0]           img_size,
	input  logic                  bsram_write,
	input  logic                  sd_ack,
	output cart_pkg::cart_info_t  info,
	output logic                  pal,
	output host_pkg::cheat_code_t cheat,
	output logic                  cheat_valid,
	output logic                  cheat_clear,
	output logic [FILL_BITS-1:0]  fill_addr,
	output logic [7:0]            fill_data,
	output logic                  fill_we,
	output host_pkg::sd_req_t     sd,
	output logic                  bk_busy,
	output logic                  core_reset,
	output logic                  led_user
);
	import host_pkg::*;

	logic      cart_download;
	logic      code_download;
	logic      code_clear;
	logic      pending;
	bk_state_e bk_state;

	// Cheat files arrive on their own download index
	assign code_download = download && (dl_index == CHEAT_INDEX);
	assign cart_download = download && (dl_index != CHEAT_INDEX);

	header_decode u_header (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cart_download (cart_download),
		.dl            (dl),
		.opts          (opts),
		.info          (info),
		.pal           (pal)
	);

	cheat_decode u_cheat (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.code_download (code_download),
		.dl            (dl),
		.cheat         (cheat),
		.cheat_valid   (cheat_valid),
		.cheat_clear   (code_clear)
	);

	ram_clear #(
		.FILL_BITS (FILL_BITS)
	) u_clear (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cart_download (cart_download),
		.pattern       (opts.fill_pattern),
		.fill_addr     (fill_addr),
		.fill_data     (fill_data),
		.fill_we       (fill_we)
	);

	// Core is held in reset while the RAM is swept
	backup_sequencer u_backup (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cart_download (cart_download),
		.ram_mask      (info.ram_mask),
		.opts          (opts),
		.osd_open      (osd_open),
		.img_mounted   (img_mounted),
		.img_readonly  (img_readonly),
		.img_size      (img_size),
		.bsram_write   (bsram_write & ~fill_we),
		.sd_ack        (sd_ack),
		.sd            (sd),
		.state         (bk_state),
		.pending       (pending)
	);

	assign cheat_clear = cart_download | code_clear;
	assign bk_busy     = (bk_state != bk_idle);
	assign core_reset  = reset | cart_download | (bk_state == bk_loading) | fill_we;
	assign led_user    = cart_download | (opts.autosave & pending);

endmodule

/* sim/tb_cart_loader.sv */
//==========================================================
// Cartridge load controller testbench
// Random header, cheat, RAM clear and backup RAM traffic
// checked against a reference model, with an SD responder
//==========================================================

`timescale 1ns/1ns

module tb_cart_loader;
	import cart_pkg::*;
	import host_pkg::*;

	localparam int FILL_BITS = 10;

	logic                 clk_sys = 1'b0;
	logic                 reset;
	logic                 download;
	logic [7:0]           dl_index;
	dl_word_t             dl;
	cart_opts_t           opts;
	logic                 osd_open;
	logic                 img_mounted;
	logic                 img_readonly;
	logic [31:0]          img_size;
	logic                 bsram_write;
	logic                 sd_ack;
	cart_info_t           info;
	logic                 pal;
	cheat_code_t          cheat;
	logic                 cheat_valid;
	logic                 cheat_clear;
	logic [FILL_BITS-1:0] fill_addr;
	logic [7:0]           fill_data;
	logic                 fill_we;
	sd_req_t              sd;
	logic                 bk_busy;
	logic                 core_reset;
	logic                 led_user;

	logic [31:0] seed;
	cart_info_t  exp_info;
	logic [31:0] rd_lbas[$];
	logic [31:0] wr_lbas[$];
	logic        rd_seen = 1'b0;
	logic        wr_seen = 1'b0;

	cart_loader_top #(
		.FILL_BITS (FILL_BITS)
	) DUT (.*);

	always #5 clk_sys = ~clk_sys;

	//==========================================================
	// Checking and reference model
	//==========================================================

	task automatic abort_run();
		$display("test failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [127:0] actual,
			input logic [127:0] expected);
		if (actual !== expected) begin
			$display("Error at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
			abort_run();
		end
	endtask

	// Address mask for a header size code
	function automatic logic [23:0] size_mask(input logic [3:0] s);
		logic [39:0] full;
		full = (40'd1024 << s) - 40'd1;
		return full[23:0];
	endfunction

	function automatic cart_info_t header_model(input hdr_mode_e mode, input logic [15:0] w0,
			input logic [15:0] w2, input logic [15:0] w_rom, input logic [15:0] w_ram);
		cart_info_t r;
		logic [3:0] rom_s;
		logic [3:0] ram_s;
		rom_s = 4'hC;
		ram_s = 4'h0;
		if (mode == hdr_auto && w0[7:0] != 8'h00) begin
			ram_s = w0[7:4];
			rom_s = w0[3:0];
		end
		if (mode == hdr_lorom || mode == hdr_hirom || mode == hdr_exhirom) begin
			rom_s = w_rom[11:8];
			ram_s = w_ram[3:0];
		end
		case (mode)
			hdr_hirom:   r.rom_type = 8'd1;
			hdr_exhirom: r.rom_type = 8'd2;
			hdr_auto:    r.rom_type = w0[15:8];
			default:     r.rom_type = 8'd0;
		endcase
		r.rom_mask = size_mask(rom_s);
		r.ram_mask = (ram_s == 4'h0) ? 24'd0 : size_mask(ram_s);
		r.region   = w2[8];
		return r;
	endfunction

	function automatic logic [7:0] fill_model(input fill_pattern_e pat, input int a);
		case (pat)
			fill_9966: return (a[8] ^ a[2]) ? 8'h66 : 8'h99;
			fill_00ff: return (a[9] ^ a[0]) ? 8'hFF : 8'h00;
			fill_55:   return 8'h55;
			default:   return 8'hFF;
		endcase
	endfunction

	//==========================================================
	// Stimulus tasks
	//==========================================================

	task automatic wait_busy(input logic level, input int limit);
		int n;
		n = 0;
		while (bk_busy !== level) begin
			if (n >= limit) begin
				$display("Timeout: bk_busy did not reach %0d within %0d cycles", level, limit);
				abort_run();
			end
			n++;
			@(negedge clk_sys);
		end
	endtask

	// Cartridge download, header writes ride along the RAM sweep
	task automatic run_download(input hdr_mode_e mode, input fill_pattern_e pat,
			input logic [15:0] w0, input logic [15:0] w2,
			input logic [15:0] w_rom, input logic [15:0] w_ram);
		dl_word_t    q[$];
		dl_word_t    w;
		logic [31:0] base;
		int          count;
		int          waited;
		case (mode)
			hdr_lorom:   base = LOROM_HDR;
			hdr_hirom:   base = HIROM_HDR;
			hdr_exhirom: base = EXHIROM_HDR;
			default:     base = 32'd0;
		endcase
		w.wr   = 1'b1;
		w.addr = 25'd0;
		w.data = w0;
		q.push_back(w);
		w.addr = 25'd2;
		w.data = w2;
		q.push_back(w);
		if (base != 32'd0) begin
			w.addr = 25'(base + HEADER_SKIP);
			w.data = w_rom;
			q.push_back(w);
			w.addr = 25'(base + HEADER_SKIP + 32'd2);
			w.data = w_ram;
			q.push_back(w);
		end
		exp_info = header_model(mode, w0, w2, w_rom, w_ram);

		opts.hdr_mode     = mode;
		opts.fill_pattern = pat;
		dl_index          = 8'h01;
		download          = 1'b1;
		waited            = 0;
		@(negedge clk_sys);
		while (!fill_we) begin
			if (waited >= 4) begin
				$display("Timeout: fill_we did not rise after the download started");
				abort_run();
			end
			waited++;
			@(negedge clk_sys);
		end

		count = 0;
		while (fill_we) begin
			check_value("fill_addr", fill_addr, count);
			check_value("fill_data", fill_data, fill_model(pat, count));
			check_value("core_reset", core_reset, 1);
			if (q.size() > 0)
				dl = q.pop_front();
			else
				dl.wr = 1'b0;
			count++;
			if (count > 2000) begin
				$display("Timeout: fill_we stayed high past 2000 cycles");
				abort_run();
			end
			@(negedge clk_sys);
		end
		check_value("fill_we cycles", count, 1024);

		dl.wr    = 1'b0;
		download = 1'b0;
		@(negedge clk_sys);
		check_value("info", info, exp_info);
	endtask

	task automatic check_region(input logic region);
		int sel;
		for (sel = 0; sel < 4; sel++) begin
			opts.region_sel = 2'(sel);
			@(negedge clk_sys);
			check_value("pal", pal, (sel == 0) ? region : sel[0]);
		end
	endtask

	task automatic run_cheat();
		logic [15:0] words[8];
		cheat_code_t exp_code;
		int          k;
		int          pulses;
		for (k = 0; k < 8; k++)
			words[k] = 16'($random(seed));
		exp_code.flags   = {words[1], words[0]};
		exp_code.address = {words[3], words[2]};
		exp_code.compare = {words[5], words[4]};
		exp_code.replace = {words[7], words[6]};

		dl_index = CHEAT_INDEX;
		download = 1'b1;
		pulses   = 0;
		for (k = 0; k < 8; k++) begin
			dl.addr = 25'(2 * k);
			dl.data = words[k];
			dl.wr   = 1'b1;
			@(negedge clk_sys);
			pulses += cheat_valid;
			if (k == 0)
				check_value("cheat_clear", cheat_clear, 1);
			if (k == 1)
				check_value("cheat_clear", cheat_clear, 0);
			check_value("fill_we", fill_we, 0);
		end
		dl.wr    = 1'b0;
		download = 1'b0;
		for (k = 0; k < 4; k++) begin
			@(negedge clk_sys);
			pulses += cheat_valid;
		end
		check_value("cheat_valid pulses", pulses, 1);
		check_value("cheat", cheat, exp_code);
	endtask

	task automatic check_sectors(input logic saving, input logic [23:0] mask);
		int n;
		int i;
		n = int'(mask[23:9]) + 1;
		if (saving) begin
			check_value("wr request count", wr_lbas.size(), n);
			check_value("rd request count", rd_lbas.size(), 0);
			for (i = 0; i < n; i++)
				check_value("sd.lba", wr_lbas[i], i);
		end else begin
			check_value("rd request count", rd_lbas.size(), n);
			check_value("wr request count", wr_lbas.size(), 0);
			for (i = 0; i < n; i++)
				check_value("sd.lba", rd_lbas[i], i);
		end
	endtask

	//==========================================================
	// SD responder and request monitor
	//==========================================================

	initial begin
		logic [31:0] r;
		int          delay;
		int          hold;
		sd_ack = 1'b0;
		forever begin
			@(negedge clk_sys);
			if ((sd.rd || sd.wr) && !sd_ack) begin
				r     = $random(seed);
				delay = 1 + int'(r[2:0]);
				hold  = 1 + int'(r[5:4]);
				repeat (delay) @(negedge clk_sys);
				sd_ack = 1'b1;
				repeat (hold) @(negedge clk_sys);
				sd_ack = 1'b0;
			end
		end
	end

	// Log the lba of every new request
	always @(negedge clk_sys) begin
		if (sd.rd === 1'b1 && !rd_seen)
			rd_lbas.push_back(sd.lba);
		if (sd.wr === 1'b1 && !wr_seen)
			wr_lbas.push_back(sd.lba);
		rd_seen = (sd.rd === 1'b1);
		wr_seen = (sd.wr === 1'b1);
	end

	//==========================================================
	// Main sequence
	//==========================================================

	initial begin
		logic [31:0] r;
		logic [31:0] r2;
		logic [3:0]  ram_s;
		int          i;
		seed         = 32'hce528020;
		reset        = 1'b1;
		download     = 1'b0;
		dl_index     = 8'h00;
		dl           = '0;
		opts         = '0;
		osd_open     = 1'b0;
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		img_size     = 32'd0;
		bsram_write  = 1'b0;
		repeat (2) @(negedge clk_sys);
		reset = 1'b0;
		check_value("fill_we", fill_we, 0);
		check_value("cheat_valid", cheat_valid, 0);
		check_value("sd.rd", sd.rd, 0);
		check_value("sd.wr", sd.wr, 0);
		check_value("bk_busy", bk_busy, 0);

		// Header decode over every mode and fill pattern
		for (i = 0; i < 6; i++) begin
			r  = $random(seed);
			r2 = $random(seed);
			run_download(hdr_mode_e'(i % 5), fill_pattern_e'(i % 4),
				r[15:0], r[31:16], r2[15:0], r2[31:16]);
			check_region(r[24]);
		end

		run_cheat();
		run_cheat();

		// Save file pulled in at the end of the download
		r     = $random(seed);
		r2    = $random(seed);
		ram_s = 4'(1 + (r[7:0] % 7));
		img_mounted = 1'b1;
		img_size    = 32'h2000 + {24'd0, r[31:24]};
		rd_lbas.delete();
		wr_lbas.delete();
		run_download(hdr_auto, fill_pattern_e'(r[21:20]), {r[15:8], ram_s, r[19:16]},
			r2[15:0], r2[31:16], r2[15:0]);
		wait_busy(1'b1, 10);
		wait_busy(1'b0, 20000);
		@(negedge clk_sys);
		check_sectors(1'b0, exp_info.ram_mask);

		// Dirty RAM saved when the menu opens
		opts.autosave = 1'b1;
		bsram_write   = 1'b1;
		@(negedge clk_sys);
		bsram_write = 1'b0;
		check_value("led_user", led_user, 1);
		rd_lbas.delete();
		wr_lbas.delete();
		osd_open = 1'b1;
		wait_busy(1'b1, 10);
		wait_busy(1'b0, 20000);
		@(negedge clk_sys);
		check_value("led_user", led_user, 0);
		check_sectors(1'b1, exp_info.ram_mask);
		osd_open = 1'b0;

		// No RAM in the header, backup stays off
		r = $random(seed);
		rd_lbas.delete();
		wr_lbas.delete();
		run_download(hdr_auto, fill_55, {r[15:8], 8'h00}, r[31:16], 16'h0, 16'h0);
		opts.bk_save = 1'b1;
		repeat (200) begin
			@(negedge clk_sys);
			check_value("bk_busy", bk_busy, 0);
		end
		check_value("rd request count", rd_lbas.size(), 0);
		check_value("wr request count", wr_lbas.size(), 0);
		opts.bk_save = 1'b0;

		$display("test passed");
		$finish;
	end

endmodule

/* all.f */
source/cart_pkg.sv
source/host_pkg.sv
source/header_decode.sv
source/cheat_decode.sv
source/ram_clear.sv
source/backup_sequencer.sv
source/cart_loader_top.sv
sim/tb_cart_loader.sv

/* run.sh */
#!/bin/sh
# Compile and run the cartridge loader testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_cart_loader -f all.f -o tb_cart_loader

out=$(./obj_dir/tb_cart_loader || true)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "test passed"
